// ==== vlog.f ====
design/eth_pkg.sv
design/pkt_ring.sv
design/gmii_tx.sv
design/gmii_rx.sv
design/host_port.sv
design/eth_mac_top.sv
sim/tb_eth_mac.sv

// ==== Makefile ====
TOP  = tb_eth_mac
PASS = Test completed successfully

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module eth_mac_top -f vlog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir

// ==== sim/tb_eth_mac.sv ====
`timescale 1ns/1ps

module tb_eth_mac;

	localparam int RING_SLOTS = 4;
	localparam int PKT_BYTES  = 64;
	localparam int LEN_W      = $clog2(PKT_BYTES + 1);
	localparam int GAP        = 12;
	localparam int TX_FRAMES  = 10;
	localparam int RX_GOOD    = 4;
	localparam int RX_BAD     = 6;   // two each of bad FCS, rx_er and oversize
	localparam int FRAMES     = TX_FRAMES + RX_GOOD + RX_BAD + RING_SLOTS + 1;
	localparam int MAX_CYCLES = 20 * (FRAMES * (PKT_BYTES + 30));

	logic              clock = 1'b0;
	logic              reset;
	logic              start_i;
	eth_pkg::host_op_e op_i;
	logic [LEN_W-1:0]  addr_i;
	logic [7:0]        value_i;
	logic              done_o;
	logic [7:0]        result_o;
	logic [7:0]        gmii_rxd_i;
	logic              gmii_rx_dv_i;
	logic              gmii_rx_er_i;
	logic [7:0]        gmii_txd_o;
	logic              gmii_tx_en_o;
	logic              gmii_tx_er_o;

	integer     seed = 32'hdfc1;
	int         cycles = 0;
	logic [7:0] payload [2*PKT_BYTES];
	logic [7:0] tx_exp_bytes [$];   // wire image of committed frames
	int         tx_exp_len [$];
	logic [7:0] rx_exp_bytes [$];
	int         rx_exp_len [$];
	logic [7:0] burst [$];
	logic       in_burst = 1'b0;
	int         idle_cnt = GAP;
	logic [7:0] res;
	int         len;
	int         kind;

	eth_mac_top #(.RING_SLOTS(RING_SLOTS), .PKT_BYTES(PKT_BYTES)) i_eth_mac_top (.*);

	always #5 clock = ~clock;

	task automatic abort_test(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(
		input string       name,
		input logic [31:0] got,
		input logic [31:0] want
	);
		abort_test($sformatf("Fail %s: got %h, expected %h", name, got, want));
	endtask

	function automatic int pick(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// complemented reflected CRC-32 over the payload
	function automatic logic [31:0] fcs_model(input int n);
		logic [31:0] r;
		r = 32'hffff_ffff;
		for (int i = 0; i < n; i++) begin
			r = r ^ {24'h0, payload[i]};
			for (int b = 0; b < 8; b++)
				r = r[0] ? (r >> 1) ^ 32'hedb8_8320 : r >> 1;
		end
		return ~r;
	endfunction

	task automatic make_payload(input int n);
		for (int i = 0; i < n; i++)
			payload[i] = 8'(pick(256));
	endtask

	task automatic host_cmd(input eth_pkg::host_op_e op, input int addr, input logic [7:0] value);
		start_i <= 1'b1;
		op_i    <= op;
		addr_i  <= LEN_W'(addr);
		value_i <= value;
		@(posedge clock);
		start_i <= 1'b0;
		assert (!done_o) else abort_test("done_o high without a command");
		@(posedge clock);
		assert (done_o) else abort_test("done_o did not pulse one cycle after start_i");
		res = result_o;
	endtask

	// one OP_WRITE per cycle with results checked two edges later
	task automatic write_burst(input int n);
		for (int i = 0; i <= n; i++) begin
			if (i < n) begin
				start_i <= 1'b1;
				op_i    <= eth_pkg::OP_WRITE;
				addr_i  <= LEN_W'(n - 1 - i);   // top byte first
				value_i <= payload[n - 1 - i];
			end else begin
				start_i <= 1'b0;
			end
			@(posedge clock);
			if (i > 0) begin
				assert (done_o) else abort_test("done_o missing during write burst");
				assert (result_o == 8'h00) else report_mismatch("result_o", result_o, 0);
			end
		end
	endtask

	task automatic expect_tx(input int n);
		logic [31:0] fcs;
		fcs = fcs_model(n);
		repeat (7) tx_exp_bytes.push_back(8'h55);
		tx_exp_bytes.push_back(8'hd5);
		for (int i = 0; i < n; i++)
			tx_exp_bytes.push_back(payload[i]);
		for (int i = 0; i < 4; i++)
			tx_exp_bytes.push_back(fcs[8*i +: 8]);
		tx_exp_len.push_back(n);
	endtask

	task automatic check_burst();
		int         n;
		logic [7:0] want;
		assert (tx_exp_len.size() != 0) else abort_test("frame sent with no packet committed");
		n = tx_exp_len[0];
		assert (burst.size() == n + 12)
			else report_mismatch("gmii_tx_en_o length", burst.size(), n + 12);
		for (int i = 0; i < burst.size(); i++) begin
			want = tx_exp_bytes.pop_front();
			assert (burst[i] == want) else report_mismatch("gmii_txd_o", burst[i], want);
		end
		void'(tx_exp_len.pop_front());
		idle_cnt = 0;
	endtask

	task automatic send_rx_frame(input int n, input logic bad_fcs, input logic rx_err);
		logic [31:0] fcs;
		int          err_at;
		fcs    = fcs_model(n);
		err_at = 8 + pick(n);
		if (bad_fcs)
			fcs = fcs ^ (32'h1 << pick(32));
		for (int i = 0; i < n + 12; i++) begin
			gmii_rx_dv_i <= 1'b1;
			gmii_rx_er_i <= rx_err && (i == err_at);
			if (i < 7)
				gmii_rxd_i <= 8'h55;
			else if (i == 7)
				gmii_rxd_i <= 8'hd5;
			else if (i < n + 8)
				gmii_rxd_i <= payload[i - 8];
			else
				gmii_rxd_i <= fcs[8*(i - n - 8) +: 8];
			@(posedge clock);
		end
		gmii_rx_dv_i <= 1'b0;
		gmii_rx_er_i <= 1'b0;
		gmii_rxd_i   <= 8'h00;
		repeat (GAP) @(posedge clock);
	endtask

	task automatic expect_rx(input int n);
		for (int i = 0; i < n; i++)
			rx_exp_bytes.push_back(payload[i]);
		rx_exp_len.push_back(n);
	endtask

	task automatic check_rx_head();
		int         n;
		logic [7:0] want;
		n = rx_exp_len.pop_front();
		host_cmd(eth_pkg::OP_READ_LEN, 0, 8'h00);
		assert (res == n) else report_mismatch("result_o", res, n);
		for (int i = 0; i <= n; i++) begin
			if (i < n)
				want = rx_exp_bytes.pop_front();
			else
				want = 8'h00;   // one past the end
			host_cmd(eth_pkg::OP_READ, i, 8'h00);
			assert (res == want) else report_mismatch("result_o", res, want);
		end
		host_cmd(eth_pkg::OP_READ_NEXT, 0, 8'h00);
		assert (res == 8'd0) else report_mismatch("result_o", res, 0);
	endtask

	// ------------------------------------------------------------------------
	// transmit monitor

	always @(posedge clock) begin
		if (!reset) begin
			assert (!gmii_tx_er_o) else report_mismatch("gmii_tx_er_o", gmii_tx_er_o, 0);
			if (gmii_tx_en_o) begin
				if (!in_burst) begin
					assert (idle_cnt >= GAP) else abort_test("inter-packet gap too short");
					burst.delete();
				end
				in_burst = 1'b1;
				burst.push_back(gmii_txd_o);
			end else begin
				if (in_burst)
					check_burst();
				in_burst = 1'b0;
				idle_cnt++;
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > MAX_CYCLES)
			abort_test("run stopped at the cycle limit before all tests finished");
	end

	// ------------------------------------------------------------------------
	// stimulus

	initial begin
		reset        = 1'b1;
		start_i      = 1'b0;
		op_i         = eth_pkg::OP_READ;
		addr_i       = '0;
		value_i      = 8'h00;
		gmii_rxd_i   = 8'h00;
		gmii_rx_dv_i = 1'b0;
		gmii_rx_er_i = 1'b0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		for (int f = 0; f < TX_FRAMES; f++) begin
			len = 1 + pick(PKT_BYTES);
			make_payload(len);
			while (tx_exp_len.size() >= RING_SLOTS)   // ring full
				@(posedge clock);
			write_burst(len);
			host_cmd(eth_pkg::OP_WRITE, PKT_BYTES, 8'hff);
			assert (res == 8'd1) else report_mismatch("result_o", res, 1);
			host_cmd(eth_pkg::OP_WRITE_LEN, 0, 8'h00);
			assert (res == len) else report_mismatch("result_o", res, len);
			host_cmd(eth_pkg::OP_WRITE_NEXT, 0, 8'h00);
			assert (res == 8'd0) else report_mismatch("result_o", res, 0);
			expect_tx(len);
		end
		while (tx_exp_len.size() != 0)
			@(posedge clock);

		for (int f = 0; f < RX_GOOD; f++) begin
			len = 1 + pick(PKT_BYTES - 4);
			make_payload(len);
			send_rx_frame(len, 1'b0, 1'b0);
			expect_rx(len);
			check_rx_head();
			host_cmd(eth_pkg::OP_READ_NEXT, 0, 8'h00);
			assert (res == 8'd1) else report_mismatch("result_o", res, 1);
		end

		// bad FCS, rx_er and oversize frames
		for (int f = 0; f < RX_BAD; f++) begin
			kind = f % 3;
			len  = (kind == 2) ? PKT_BYTES - 3 + pick(16) : 1 + pick(PKT_BYTES - 4);
			make_payload(len);
			send_rx_frame(len, kind == 0, kind == 1);
			host_cmd(eth_pkg::OP_READ_NEXT, 0, 8'h00);
			assert (res == 8'd1) else report_mismatch("result_o", res, 1);
		end

		// one frame more than the ring holds
		for (int f = 0; f <= RING_SLOTS; f++) begin
			len = 1 + pick(PKT_BYTES - 4);
			make_payload(len);
			send_rx_frame(len, 1'b0, 1'b0);
			if (f < RING_SLOTS)
				expect_rx(len);
		end
		for (int f = 0; f < RING_SLOTS; f++)
			check_rx_head();
		host_cmd(eth_pkg::OP_READ_NEXT, 0, 8'h00);
		assert (res == 8'd1) else report_mismatch("result_o", res, 1);

		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== design/eth_mac_top.sv ====
`timescale 1ns/1ps

module eth_mac_top #(
	parameter int RING_SLOTS = 4,
	parameter int PKT_BYTES  = 64,
	localparam int LEN_W     = $clog2(PKT_BYTES + 1),
	localparam int RES_W     = (LEN_W > 8) ? LEN_W : 8
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              start_i,
	input  eth_pkg::host_op_e op_i,
	input  logic [LEN_W-1:0]  addr_i,
	input  logic [7:0]        value_i,
	output logic              done_o,
	output logic [RES_W-1:0]  result_o,
	input  logic [7:0]        gmii_rxd_i,
	input  logic              gmii_rx_dv_i,
	input  logic              gmii_rx_er_i,
	output logic [7:0]        gmii_txd_o,
	output logic              gmii_tx_en_o,
	output logic              gmii_tx_er_o
);
	// receive ring, engine writes and host reads
	logic             rx_wr_en, rx_wr_next, rx_wr_drop, rx_wr_full;
	logic [LEN_W-1:0] rx_wr_addr, rx_rd_addr, rx_rd_len;
	logic [7:0]       rx_wr_data, rx_rd_data;
	logic             rx_rd_next, rx_rd_empty;

	// transmit ring, host writes and engine reads
	logic             tx_wr_en, tx_wr_next, tx_wr_full;
	logic [LEN_W-1:0] tx_wr_addr, tx_wr_len, tx_rd_addr, tx_rd_len;
	logic [7:0]       tx_wr_data, tx_rd_data;
	logic             tx_rd_next, tx_rd_empty;

	pkt_ring #(.RING_SLOTS(RING_SLOTS), .PKT_BYTES(PKT_BYTES), .TRIM_BYTES(eth_pkg::FCS_BYTES))
	i_rx_ring (
		.clock(clock), .reset(reset),
		.wr_en_i(rx_wr_en), .wr_addr_i(rx_wr_addr), .wr_data_i(rx_wr_data),
		.wr_next_i(rx_wr_next), .wr_drop_i(rx_wr_drop),
		.wr_full_o(rx_wr_full), .wr_len_o(),
		.rd_addr_i(rx_rd_addr), .rd_next_i(rx_rd_next),
		.rd_data_o(rx_rd_data), .rd_len_o(rx_rd_len), .rd_empty_o(rx_rd_empty)
	);

	pkt_ring #(.RING_SLOTS(RING_SLOTS), .PKT_BYTES(PKT_BYTES), .TRIM_BYTES(0))
	i_tx_ring (
		.clock(clock), .reset(reset),
		.wr_en_i(tx_wr_en), .wr_addr_i(tx_wr_addr), .wr_data_i(tx_wr_data),
		.wr_next_i(tx_wr_next), .wr_drop_i(1'b0),
		.wr_full_o(tx_wr_full), .wr_len_o(tx_wr_len),
		.rd_addr_i(tx_rd_addr), .rd_next_i(tx_rd_next),
		.rd_data_o(tx_rd_data), .rd_len_o(tx_rd_len), .rd_empty_o(tx_rd_empty)
	);

	gmii_rx #(.PKT_BYTES(PKT_BYTES)) i_gmii_rx (
		.clock(clock), .reset(reset),
		.gmii_rxd_i(gmii_rxd_i), .gmii_rx_dv_i(gmii_rx_dv_i), .gmii_rx_er_i(gmii_rx_er_i),
		.wr_full_i(rx_wr_full), .wr_en_o(rx_wr_en), .wr_addr_o(rx_wr_addr),
		.wr_data_o(rx_wr_data), .wr_next_o(rx_wr_next), .wr_drop_o(rx_wr_drop)
	);

	gmii_tx #(.PKT_BYTES(PKT_BYTES)) i_gmii_tx (
		.clock(clock), .reset(reset),
		.rd_data_i(tx_rd_data), .rd_len_i(tx_rd_len), .rd_empty_i(tx_rd_empty),
		.rd_addr_o(tx_rd_addr), .rd_next_o(tx_rd_next),
		.gmii_txd_o(gmii_txd_o), .gmii_tx_en_o(gmii_tx_en_o), .gmii_tx_er_o(gmii_tx_er_o)
	);

	host_port #(.PKT_BYTES(PKT_BYTES)) i_host_port (
		.clock(clock), .reset(reset),
		.start_i(start_i), .op_i(op_i), .addr_i(addr_i), .value_i(value_i),
		.done_o(done_o), .result_o(result_o),
		.tx_wr_en_o(tx_wr_en), .tx_wr_addr_o(tx_wr_addr), .tx_wr_data_o(tx_wr_data),
		.tx_wr_next_o(tx_wr_next), .tx_wr_full_i(tx_wr_full), .tx_wr_len_i(tx_wr_len),
		.rx_rd_addr_o(rx_rd_addr), .rx_rd_next_o(rx_rd_next), .rx_rd_data_i(rx_rd_data),
		.rx_rd_len_i(rx_rd_len), .rx_rd_empty_i(rx_rd_empty)
	);

endmodule

// ==== design/host_port.sv ====
`timescale 1ns/1ps

module host_port #(
	parameter int PKT_BYTES = 64,
	localparam int LEN_W    = $clog2(PKT_BYTES + 1),
	localparam int RES_W    = (LEN_W > 8) ? LEN_W : 8
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               start_i,
	input  eth_pkg::host_op_e  op_i,
	input  logic [LEN_W-1:0]   addr_i,
	input  logic [7:0]         value_i,
	output logic               done_o,
	output logic [RES_W-1:0]   result_o,
	output logic               tx_wr_en_o,
	output logic [LEN_W-1:0]   tx_wr_addr_o,
	output logic [7:0]         tx_wr_data_o,
	output logic               tx_wr_next_o,
	input  logic               tx_wr_full_i,
	input  logic [LEN_W-1:0]   tx_wr_len_i,
	output logic [LEN_W-1:0]   rx_rd_addr_o,
	output logic               rx_rd_next_o,
	input  logic [7:0]         rx_rd_data_i,
	input  logic [LEN_W-1:0]   rx_rd_len_i,
	input  logic               rx_rd_empty_i
);
	logic             addr_over;
	logic             read_q;     // result comes from the ring read port
	logic [RES_W-1:0] status_q;

	assign addr_over    = (addr_i >= LEN_W'(PKT_BYTES));
	assign tx_wr_en_o   = start_i && (op_i == eth_pkg::OP_WRITE) && !addr_over;
	assign tx_wr_addr_o = addr_i;
	assign tx_wr_data_o = value_i;
	assign tx_wr_next_o = start_i && (op_i == eth_pkg::OP_WRITE_NEXT);
	assign rx_rd_addr_o = addr_i;
	assign rx_rd_next_o = start_i && (op_i == eth_pkg::OP_READ_NEXT);

	always_ff @(posedge clock) begin
		if (reset) begin
			done_o   <= 1'b0;
			read_q   <= 1'b0;
			status_q <= '0;
		end else begin
			done_o <= start_i;
			read_q <= start_i && (op_i == eth_pkg::OP_READ);
			if (start_i) begin
				case (op_i)
					eth_pkg::OP_READ_LEN:   status_q <= RES_W'(rx_rd_len_i);
					eth_pkg::OP_READ_NEXT:  status_q <= RES_W'(rx_rd_empty_i);
					eth_pkg::OP_WRITE:      status_q <= RES_W'(addr_over);
					eth_pkg::OP_WRITE_LEN:  status_q <= RES_W'(tx_wr_len_i);
					eth_pkg::OP_WRITE_NEXT: status_q <= RES_W'(tx_wr_full_i);
					default:                status_q <= '0;
				endcase
			end
		end
	end

	assign result_o = read_q ? RES_W'(rx_rd_data_i) : status_q;

endmodule

// ==== design/gmii_rx.sv ====
`timescale 1ns/1ps

module gmii_rx #(
	parameter int PKT_BYTES = 64,
	localparam int LEN_W    = $clog2(PKT_BYTES + 1)
) (
	input  logic             clock,
	input  logic             reset,
	input  logic [7:0]       gmii_rxd_i,
	input  logic             gmii_rx_dv_i,
	input  logic             gmii_rx_er_i,
	input  logic             wr_full_i,
	output logic             wr_en_o,
	output logic [LEN_W-1:0] wr_addr_o,
	output logic [7:0]       wr_data_o,
	output logic             wr_next_o,
	output logic             wr_drop_o
);
	eth_pkg::rx_state_e state_q;
	logic [2:0]         pre_cnt_q;
	logic [LEN_W-1:0]   addr_q;
	logic [31:0]        crc_q;
	logic               is_pre;
	logic               is_sfd;

	assign is_pre = gmii_rx_dv_i && !gmii_rx_er_i && (gmii_rxd_i == eth_pkg::PREAMBLE_BYTE);
	assign is_sfd = gmii_rx_dv_i && !gmii_rx_er_i && (gmii_rxd_i == eth_pkg::SFD_BYTE);

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q   <= eth_pkg::RX_IDLE;
			pre_cnt_q <= '0;
			wr_en_o   <= 1'b0;
			wr_next_o <= 1'b0;
			wr_drop_o <= 1'b0;
		end else begin
			wr_en_o   <= 1'b0;
			wr_next_o <= 1'b0;
			wr_drop_o <= 1'b0;
			case (state_q)
				eth_pkg::RX_IDLE: begin
					if (is_pre) begin
						pre_cnt_q <= 3'd1;
						state_q   <= eth_pkg::RX_PREAMBLE;
					end
				end
				eth_pkg::RX_PREAMBLE: begin
					if (is_pre && pre_cnt_q != 3'(eth_pkg::PREAMBLE_LEN)) begin
						pre_cnt_q <= pre_cnt_q + 1'b1;
					end else if (is_sfd && pre_cnt_q == 3'(eth_pkg::PREAMBLE_LEN)) begin
						crc_q     <= eth_pkg::CRC_INIT;
						addr_q    <= '0;
						wr_drop_o <= 1'b1;   // fresh open slot
						state_q   <= wr_full_i ? eth_pkg::RX_DROP : eth_pkg::RX_DATA;
					end else begin
						state_q <= eth_pkg::RX_IDLE;
					end
				end
				eth_pkg::RX_DATA: begin
					if (!gmii_rx_dv_i) begin
						if (crc_q == eth_pkg::CRC_RESIDUE)
							wr_next_o <= 1'b1;
						else
							wr_drop_o <= 1'b1;
						state_q <= eth_pkg::RX_IDLE;
					end else if (gmii_rx_er_i || addr_q == LEN_W'(PKT_BYTES)) begin
						state_q <= eth_pkg::RX_DROP;   // error or slot overflow
					end else begin
						wr_en_o   <= 1'b1;
						wr_addr_o <= addr_q;
						wr_data_o <= gmii_rxd_i;
						addr_q    <= addr_q + 1'b1;
						crc_q     <= eth_pkg::next_crc32_d8(gmii_rxd_i, crc_q);
					end
				end
				eth_pkg::RX_DROP: begin
					if (!gmii_rx_dv_i) begin
						wr_drop_o <= 1'b1;
						state_q   <= eth_pkg::RX_IDLE;
					end
				end
				default: state_q <= eth_pkg::RX_IDLE;
			endcase
		end
	end

endmodule

// ==== design/gmii_tx.sv ====
`timescale 1ns/1ps

module gmii_tx #(
	parameter int PKT_BYTES = 64,
	localparam int LEN_W    = $clog2(PKT_BYTES + 1)
) (
	input  logic             clock,
	input  logic             reset,
	input  logic [7:0]       rd_data_i,
	input  logic [LEN_W-1:0] rd_len_i,
	input  logic             rd_empty_i,
	output logic [LEN_W-1:0] rd_addr_o,
	output logic             rd_next_o,
	output logic [7:0]       gmii_txd_o,
	output logic             gmii_tx_en_o,
	output logic             gmii_tx_er_o
);
	eth_pkg::tx_state_e state_q;
	logic [LEN_W:0]     byte_q;    // read address, one ahead of the byte on the wire
	logic [LEN_W-1:0]   len_q;
	logic [3:0]         pre_cnt_q;
	logic [3:0]         gap_cnt_q; // also steps the FCS bytes
	logic [31:0]        crc_q;

	// complemented, MSB of the register first on the wire
	function automatic logic [7:0] fcs_byte(input logic [31:0] crc);
		logic [7:0] b;
		for (int i = 0; i < 8; i++)
			b[i] = ~crc[31 - i];
		return b;
	endfunction

	assign rd_addr_o    = byte_q[LEN_W-1:0];
	assign gmii_tx_er_o = 1'b0;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q      <= eth_pkg::TX_IDLE;
			byte_q       <= '0;
			pre_cnt_q    <= '0;
			gap_cnt_q    <= '0;
			rd_next_o    <= 1'b0;
			gmii_tx_en_o <= 1'b0;
			gmii_txd_o   <= 8'h00;
		end else begin
			rd_next_o <= 1'b0;
			case (state_q)
				eth_pkg::TX_IDLE: begin
					byte_q <= '0;
					if (!rd_empty_i) begin
						len_q        <= rd_len_i;
						crc_q        <= eth_pkg::CRC_INIT;
						pre_cnt_q    <= 4'd1;
						gmii_tx_en_o <= 1'b1;
						gmii_txd_o   <= eth_pkg::PREAMBLE_BYTE;
						state_q      <= eth_pkg::TX_PREAMBLE;
					end
				end
				eth_pkg::TX_PREAMBLE: begin
					if (pre_cnt_q == 4'(eth_pkg::PREAMBLE_LEN)) begin
						gmii_txd_o <= eth_pkg::SFD_BYTE;
						byte_q     <= 1;   // byte 0 already requested
						state_q    <= eth_pkg::TX_SFD;
					end else begin
						gmii_txd_o <= eth_pkg::PREAMBLE_BYTE;
						pre_cnt_q  <= pre_cnt_q + 1'b1;
					end
				end
				eth_pkg::TX_SFD, eth_pkg::TX_DATA: begin
					if (byte_q <= {1'b0, len_q}) begin
						gmii_txd_o <= rd_data_i;
						crc_q      <= eth_pkg::next_crc32_d8(rd_data_i, crc_q);
						byte_q     <= byte_q + 1'b1;
						state_q    <= eth_pkg::TX_DATA;
					end else begin
						gmii_txd_o <= fcs_byte(crc_q);
						crc_q      <= crc_q << 8;
						gap_cnt_q  <= 4'd1;
						state_q    <= eth_pkg::TX_FCS;
					end
				end
				eth_pkg::TX_FCS: begin
					if (gap_cnt_q == 4'(eth_pkg::FCS_BYTES)) begin
						gmii_tx_en_o <= 1'b0;
						gmii_txd_o   <= 8'h00;
						rd_next_o    <= 1'b1;   // frame is out, free the slot
						gap_cnt_q    <= 4'd1;
						state_q      <= eth_pkg::TX_GAP;
					end else begin
						gmii_txd_o <= fcs_byte(crc_q);
						crc_q      <= crc_q << 8;
						gap_cnt_q  <= gap_cnt_q + 1'b1;
					end
				end
				eth_pkg::TX_GAP: begin
					if (gap_cnt_q == 4'(eth_pkg::GAP_CYCLES))
						state_q <= eth_pkg::TX_IDLE;
					else
						gap_cnt_q <= gap_cnt_q + 1'b1;
				end
				default: state_q <= eth_pkg::TX_IDLE;
			endcase
		end
	end

endmodule

// ==== design/pkt_ring.sv ====
`timescale 1ns/1ps

module pkt_ring #(
	parameter int RING_SLOTS = 4,
	parameter int PKT_BYTES  = 64,
	parameter int TRIM_BYTES = 0,
	localparam int LEN_W     = $clog2(PKT_BYTES + 1)
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             wr_en_i,
	input  logic [LEN_W-1:0] wr_addr_i,
	input  logic [7:0]       wr_data_i,
	input  logic             wr_next_i,
	input  logic             wr_drop_i,
	output logic             wr_full_o,
	output logic [LEN_W-1:0] wr_len_o,
	input  logic [LEN_W-1:0] rd_addr_i,
	input  logic             rd_next_i,
	output logic [7:0]       rd_data_o,
	output logic [LEN_W-1:0] rd_len_o,
	output logic             rd_empty_o
);
	localparam int IDX_W = (PKT_BYTES > 1) ? $clog2(PKT_BYTES) : 1;
	localparam int PTR_W = (RING_SLOTS > 1) ? $clog2(RING_SLOTS) : 1;
	localparam int CNT_W = $clog2(RING_SLOTS + 1);

	logic [7:0]       mem [RING_SLOTS][PKT_BYTES];
	logic [LEN_W-1:0] len_q [RING_SLOTS];    // committed lengths
	logic [PTR_W-1:0] wr_ptr_q;              // open slot
	logic [PTR_W-1:0] rd_ptr_q;              // head packet
	logic [CNT_W-1:0] count_q;
	logic [LEN_W-1:0] open_len_q;
	logic [LEN_W-1:0] trim_len;
	logic             wr_ok;
	logic             do_commit;
	logic             do_release;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(RING_SLOTS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign wr_full_o  = (count_q == CNT_W'(RING_SLOTS));
	assign rd_empty_o = (count_q == '0);
	assign wr_len_o   = open_len_q;
	assign rd_len_o   = rd_empty_o ? '0 : len_q[rd_ptr_q];

	// no open slot while full, the head would be overwritten
	assign wr_ok = wr_en_i && !wr_full_o && (wr_addr_i < LEN_W'(PKT_BYTES));

	assign trim_len = (open_len_q > LEN_W'(TRIM_BYTES)) ?
		open_len_q - LEN_W'(TRIM_BYTES) : '0;
	assign do_commit  = wr_next_i && (trim_len != '0) && !wr_full_o;
	assign do_release = rd_next_i && !rd_empty_o;

	// ------------------------------------------------------------------------
	// byte storage, registered read of the head packet

	always_ff @(posedge clock) begin
		if (wr_ok)
			mem[wr_ptr_q][wr_addr_i[IDX_W-1:0]] <= wr_data_i;
		if (rd_addr_i < rd_len_o)
			rd_data_o <= mem[rd_ptr_q][rd_addr_i[IDX_W-1:0]];
		else
			rd_data_o <= 8'h00;   // past the end or empty
	end

	// ------------------------------------------------------------------------
	// slot pointers and lengths

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			count_q    <= '0;
			open_len_q <= '0;
		end else begin
			if (do_commit) begin
				len_q[wr_ptr_q] <= trim_len;
				wr_ptr_q        <= ptr_inc(wr_ptr_q);
				open_len_q      <= '0;
			end else if (wr_drop_i) begin
				open_len_q <= '0;
			end else if (wr_ok && wr_addr_i >= open_len_q) begin
				open_len_q <= wr_addr_i + 1'b1;   // highest byte so far
			end

			if (do_release)
				rd_ptr_q <= ptr_inc(rd_ptr_q);

			if (do_commit && !do_release)
				count_q <= count_q + 1'b1;
			else if (do_release && !do_commit)
				count_q <= count_q - 1'b1;
		end
	end

endmodule

// ==== design/eth_pkg.sv ====
package eth_pkg;

	typedef enum logic [2:0] {
		OP_READ       = 3'd0,
		OP_READ_LEN   = 3'd1,
		OP_READ_NEXT  = 3'd2,
		OP_WRITE      = 3'd3,
		OP_WRITE_LEN  = 3'd4,
		OP_WRITE_NEXT = 3'd5
	} host_op_e;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_PREAMBLE,
		TX_SFD,
		TX_DATA,
		TX_FCS,
		TX_GAP
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_PREAMBLE,
		RX_DATA,
		RX_DROP
	} rx_state_e;

	// ------------------------------------------------------------------------
	// framing

	localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0]  SFD_BYTE      = 8'hd5;
	localparam int          PREAMBLE_LEN  = 7;
	localparam int          FCS_BYTES     = 4;
	localparam int          GAP_CYCLES    = 12;

	localparam logic [31:0] CRC_POLY      = 32'h04c1_1db7;
	localparam logic [31:0] CRC_INIT      = 32'hffff_ffff;
	localparam logic [31:0] CRC_RESIDUE   = 32'hc704_dd7b;   // register after a good FCS

	// one byte of CRC-32, bit 0 goes out on the wire first
	function automatic logic [31:0] next_crc32_d8(input logic [7:0] data, input logic [31:0] crc);
		logic [31:0] c;
		logic        fb;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			fb = c[31] ^ data[i];
			c  = {c[30:0], 1'b0};
			if (fb)
				c = c ^ CRC_POLY;
		end
		return c;
	endfunction

endpackage
